// ==== Bender.yml ====
package:
  name: rv32_single_cycle

dependencies: {}

export_include_dirs:
  - include

sources:
  - files:
      - verilog/rv_pkg.sv
      - verilog/alu.sv
      - verilog/imm_extend.sv
      - verilog/reg_file.sv
      - verilog/control.sv
      - verilog/cpu.sv
  - target: test
    files:
      - tb/cpu_props.sv
      - tb/cpu_tb.sv

// ==== include/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data path and address width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NUM_REGS 32

// PC value held while rst is high
`define RV_RESET_PC 32'h0000_0000

// Major opcodes of the supported RV32I subset

// lw
`define RV_OP_LOAD 7'b0000011

// addi and the rest of the ALU immediate group
`define RV_OP_ALUI 7'b0010011

// sw
`define RV_OP_STORE 7'b0100011

// add, sub, and, or
`define RV_OP_ALU 7'b0110011

// beq
`define RV_OP_BRANCH 7'b1100011

// jal
`define RV_OP_JAL 7'b1101111

// Anything else is treated as a no-op by the core:
// no register write, no store, pc advances by 4

`endif

// ==== sim.f ====
+incdir+include
verilog/rv_pkg.sv
verilog/alu.sv
verilog/imm_extend.sv
verilog/reg_file.sv
verilog/control.sv
verilog/cpu.sv
tb/cpu_props.sv
tb/cpu_tb.sv

// ==== tb/cpu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module cpu_props (
    input logic                clk,
    input logic                rst,
    input logic [`RV_XLEN-1:0] pc,
    input logic [`RV_XLEN-1:0] instr,
    input logic                data_we
);

    // Failed assertions, summed into the testbench error count
    int unsigned failures = 0;

    // No memory writes while held in reset
    a_no_store_in_reset: assert property (@(posedge clk) rst |-> !data_we)
        else begin
            failures++;
            $error("data_we high while rst is high");
        end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else begin
            failures++;
            $error("pc not word aligned: %h", pc);
        end

    a_pc_after_reset: assert property (@(posedge clk) rst |=> pc == `RV_RESET_PC)
        else begin
            failures++;
            $error("pc not at the reset value after a reset cycle: %h", pc);
        end

    // Only sw may write data memory
    a_store_only: assert property (@(posedge clk) disable iff (rst)
        (instr[6:0] != `RV_OP_STORE) |-> !data_we)
        else begin
            failures++;
            $error("data_we high for opcode %b", instr[6:0]);
        end

endmodule

bind cpu cpu_props cpu_props_inst (
    .clk     (clk),
    .rst     (rst),
    .pc      (pc),
    .instr   (instr),
    .data_we (data_we)
);

`default_nettype wire

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module cpu_tb;

    import rv_pkg::*;

    localparam int RESET_CYCLES  = 8;
    localparam int RESET_TIMEOUT = 4;
    localparam int STORE_TARGET  = 32;
    localparam int RUN_TIMEOUT   = 3000;

    // Opcodes outside the supported subset
    localparam logic [6:0] UNKNOWN_OPS [4] = '{7'b0110111, 7'b0010111, 7'b1100111, 7'b1110011};

    // sw x1, 0(x0) seen on the fetch port while rst is high
    localparam logic [31:0] RESET_FETCH = {7'd0, 5'd1, 5'd0, 3'b010, 5'd0, `RV_OP_STORE};

    logic                clk;
    logic                rst;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] instr;
    logic [`RV_XLEN-1:0] data_addr;
    logic [`RV_XLEN-1:0] data_wdata;
    logic                data_we;
    logic [`RV_XLEN-1:0] data_rdata;

    logic [`RV_XLEN-1:0] imem [64];
    logic [`RV_XLEN-1:0] dmem [64];

    // Reference model state
    logic [`RV_XLEN-1:0] ref_pc;
    logic [`RV_XLEN-1:0] ref_regs [`RV_NUM_REGS];
    logic [`RV_XLEN-1:0] ref_mem [64];

    int errors;
    int timeouts;
    int checks;
    int stores_seen;
    int cycles;

    cpu cpu_inst (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .instr      (instr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .data_rdata (data_rdata)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Both memories answer in the same cycle
    assign instr      = rst ? RESET_FETCH : imem[pc[7:2]];
    assign data_rdata = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (data_we) begin
            dmem[data_addr[7:2]] <= data_wdata;
        end
    end

    function automatic logic [31:0] fill_word(int unsigned k);
        return 32'hd00d_0000 ^ ((k << 2) * 32'h0001_0001);
    endfunction

    // One random instruction for word idx, control flow stays inside the array
    function automatic logic [31:0] random_instr(int idx);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [11:0] moff;
        logic [12:0] boff;
        logic [20:0] joff;
        int          target;
        rd     = 5'($urandom_range(0, 7));
        rs1    = 5'($urandom_range(0, 7));
        rs2    = 5'($urandom_range(0, 7));
        f3     = 3'($urandom());
        f7     = $urandom_range(0, 1) ? 7'h20 : 7'h00;
        imm    = 12'($urandom());
        moff   = 12'($urandom_range(0, 15) * 4);
        // Mostly short forward hops, past the end go back to word 0
        target = idx + 1 + $urandom_range(0, 7);
        if (target > 63) begin
            target = 0;
        end
        boff = 13'((target - idx) * 4);
        joff = 21'((target - idx) * 4);
        case ($urandom_range(0, 9))
            0: return {moff, 5'd0, 3'b010, rd, `RV_OP_LOAD};
            1: return {moff[11:5], rs2, 5'd0, 3'b010, moff[4:0], `RV_OP_STORE};
            2, 9: return {imm, rs1, f3, rd, `RV_OP_ALUI};
            3, 4: return {f7, rs2, rs1, f3, rd, `RV_OP_ALU};
            5, 6: return {boff[12], boff[10:5], rs2, rs1, 3'b000, boff[4:1], boff[11],
                          `RV_OP_BRANCH};
            7: return {joff[20], joff[10:1], joff[11], joff[19:12], rd, `RV_OP_JAL};
            default: return {25'($urandom()), UNKNOWN_OPS[$urandom_range(0, 3)]};
        endcase
    endfunction

    task automatic check_pc(logic [`RV_XLEN-1:0] expected, logic [`RV_XLEN-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED t=%0t pc expected=%h actual=%h", $time, expected, actual);
        end
    endtask

    task automatic check_we(logic expected, logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED t=%0t data_we expected=%b actual=%b", $time, expected, actual);
        end
    endtask

    task automatic check_store(logic [`RV_XLEN-1:0] exp_addr, logic [`RV_XLEN-1:0] exp_data,
                               logic [`RV_XLEN-1:0] act_addr, logic [`RV_XLEN-1:0] act_data);
        checks++;
        if (act_addr !== exp_addr) begin
            errors++;
            $display("FAILED t=%0t data_addr expected=%h actual=%h", $time, exp_addr, act_addr);
        end
        if (act_data !== exp_data) begin
            errors++;
            $display("FAILED t=%0t data_wdata expected=%h actual=%h", $time, exp_data, act_data);
        end
    endtask

    // Execute one instruction in the model and compare with the DUT mid-cycle
    task automatic step_model();
        instr_t              w;
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [`RV_XLEN-1:0] imm;
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] result;
        logic [`RV_XLEN-1:0] next_pc;
        logic                wr;
        w       = imem[ref_pc[7:2]];
        a       = ref_regs[w.r.rs1];
        b       = ref_regs[w.r.rs2];
        next_pc = ref_pc + 32'd4;
        result  = '0;
        wr      = 1'b0;
        check_pc(ref_pc, pc);
        check_we(w.r.opcode == `RV_OP_STORE, data_we);
        case (w.r.opcode)
            `RV_OP_LOAD: begin
                imm    = {{20{w.i.imm_11_0[11]}}, w.i.imm_11_0};
                addr   = a + imm;
                result = ref_mem[addr[7:2]];
                wr     = 1'b1;
            end
            `RV_OP_ALUI: begin
                imm    = {{20{w.i.imm_11_0[11]}}, w.i.imm_11_0};
                result = a + imm;
                wr     = 1'b1;
            end
            `RV_OP_STORE: begin
                imm  = {{20{w.s.imm_11_5[6]}}, w.s.imm_11_5, w.s.imm_4_0};
                addr = a + imm;
                check_store(addr, b, data_addr, data_wdata);
                ref_mem[addr[7:2]] = b;
                stores_seen++;
            end
            `RV_OP_ALU: begin
                case (w.r.funct3)
                    3'b000:  result = w.r.funct7[5] ? a - b : a + b;
                    3'b111:  result = a & b;
                    3'b110:  result = a | b;
                    default: result = '0;
                endcase
                wr = 1'b1;
            end
            `RV_OP_BRANCH: begin
                imm = {{20{w.b.imm_12}}, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0};
                if (a == b) begin
                    next_pc = ref_pc + imm;
                end
            end
            `RV_OP_JAL: begin
                imm     = {{12{w.j.imm_20}}, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1, 1'b0};
                result  = ref_pc + 32'd4;
                wr      = 1'b1;
                next_pc = ref_pc + imm;
            end
            default: begin
            end
        endcase
        // x0 keeps its zero
        if (wr && w.r.rd != 5'd0) begin
            ref_regs[w.r.rd] = result;
        end
        ref_pc = next_pc;
    endtask

    initial begin
        errors      = 0;
        timeouts    = 0;
        checks      = 0;
        stores_seen = 0;
        rst         = 1'b1;
        void'($urandom(32'hb1f9));
        for (int k = 0; k < 64; k++) begin
            dmem[k]    = fill_word(k);
            ref_mem[k] = fill_word(k);
            imem[k]    = random_instr(k);
        end
        // Every pass through the array starts with addi then sw
        imem[0] = {12'($urandom()), 5'd0, 3'b000, 5'd1, `RV_OP_ALUI};
        imem[1] = {7'd0, 5'd1, 5'd0, 3'b010, 5'd0, `RV_OP_STORE};
        for (int k = 0; k < `RV_NUM_REGS; k++) begin
            ref_regs[k] = '0;
        end
        ref_pc = `RV_RESET_PC;

        cycles = 0;
        while (pc !== `RV_RESET_PC && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (pc !== `RV_RESET_PC) begin
            timeouts++;
            $display("ERROR: pc did not take the reset value within %0d cycles of reset",
                     RESET_TIMEOUT);
        end
        while (cycles < RESET_CYCLES - 1) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
            check_pc(`RV_RESET_PC, pc);
            check_we(1'b0, data_we);
        end
        @(posedge clk);
        rst <= 1'b0;

        cycles = 0;
        while (stores_seen < STORE_TARGET && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            step_model();
        end
        if (stores_seen < STORE_TARGET) begin
            timeouts++;
            $display("ERROR: only %0d of %0d stores happened within %0d cycles",
                     stores_seen, STORE_TARGET, RUN_TIMEOUT);
        end

        // Failed bound assertions count as errors too
        errors += cpu_inst.cpu_props_inst.failures;

        $display("Run done: %0d cycles, %0d checks, %0d errors, %0d timeouts, %0d stores",
                 cycles, checks, errors, timeouts, stores_seen);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rv_pkg::alu_ctrl_t   alu_control,
    output logic [`RV_XLEN-1:0] result,
    output logic                zero
);

    import rv_pkg::*;

    always_comb begin
        case (alu_control)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            // ALU_NONE and any unused code
            default: begin
                result = '0;
            end
        endcase
    end

    // Used by beq after a subtract
    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== verilog/control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module control (
    input  logic [6:0]         op,
    input  logic [2:0]         func3,
    input  logic               func7_5,
    input  logic               alu_zero,
    output rv_pkg::alu_ctrl_t  alu_control,
    output rv_pkg::imm_src_t   imm_source,
    output logic               mem_write,
    output logic               reg_write,
    output logic               alu_source,
    output rv_pkg::wb_src_t    write_back_source,
    output logic               pc_source
);

    import rv_pkg::*;

    // Coarse ALU class handed from the main decoder to the ALU decoder
    localparam logic [1:0] ALU_OP_ADD  = 2'b00;
    localparam logic [1:0] ALU_OP_SUB  = 2'b01;
    localparam logic [1:0] ALU_OP_FUNC = 2'b10;

    logic [1:0] alu_op;
    logic       branch;
    logic       jump;

    // Main decoder
    always_comb begin
        // Safe values, so an unknown opcode leaves all state alone
        reg_write         = 1'b0;
        mem_write         = 1'b0;
        imm_source        = IMM_I;
        alu_source        = 1'b0;
        alu_op            = ALU_OP_ADD;
        write_back_source = WB_ALU;
        branch            = 1'b0;
        jump              = 1'b0;

        case (op)
            `RV_OP_LOAD: begin
                reg_write         = 1'b1;
                imm_source        = IMM_I;
                alu_source        = 1'b1;
                write_back_source = WB_MEM;
            end
            `RV_OP_ALUI: begin
                // Every immediate ALU op is an add here, func3 is ignored
                reg_write         = 1'b1;
                imm_source        = IMM_I;
                alu_source        = 1'b1;
                write_back_source = WB_ALU;
            end
            `RV_OP_STORE: begin
                mem_write  = 1'b1;
                imm_source = IMM_S;
                alu_source = 1'b1;
            end
            `RV_OP_ALU: begin
                reg_write         = 1'b1;
                alu_source        = 1'b0;
                alu_op            = ALU_OP_FUNC;
                write_back_source = WB_ALU;
            end
            `RV_OP_BRANCH: begin
                // Compare by subtraction, zero flag means equal
                imm_source = IMM_B;
                alu_source = 1'b0;
                alu_op     = ALU_OP_SUB;
                branch     = 1'b1;
            end
            `RV_OP_JAL: begin
                reg_write         = 1'b1;
                imm_source        = IMM_J;
                write_back_source = WB_PC4;
                jump              = 1'b1;
            end
            default: begin
                // Treated as a no-op
                reg_write = 1'b0;
                mem_write = 1'b0;
            end
        endcase
    end

    // ALU decoder
    always_comb begin
        case (alu_op)
            ALU_OP_ADD: alu_control = ALU_ADD;
            ALU_OP_SUB: alu_control = ALU_SUB;
            ALU_OP_FUNC: begin
                case (func3)
                    // funct7 bit 5 turns add into sub
                    3'b000:  alu_control = func7_5 ? ALU_SUB : ALU_ADD;
                    3'b111:  alu_control = ALU_AND;
                    3'b110:  alu_control = ALU_OR;
                    // Unsupported R-type ops produce zero
                    default: alu_control = ALU_NONE;
                endcase
            end
            default: alu_control = ALU_NONE;
        endcase
    end

    // Taken beq or any jal
    assign pc_source = (alu_zero & branch) | jump;

endmodule

`default_nettype wire

// ==== verilog/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module cpu (
    input  logic                clk,
    input  logic                rst,
    output logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] instr,
    output logic [`RV_XLEN-1:0] data_addr,
    output logic [`RV_XLEN-1:0] data_wdata,
    output logic                data_we,
    input  logic [`RV_XLEN-1:0] data_rdata
);

    import rv_pkg::*;

    instr_t              instr_word;
    logic [6:0]          opcode;

    alu_ctrl_t           alu_control;
    imm_src_t            imm_source;
    wb_src_t             write_back_source;
    logic                mem_write;
    logic                reg_write;
    logic                alu_source;
    logic                pc_source;

    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic                alu_zero;
    logic [`RV_XLEN-1:0] write_back;
    logic                rf_write_en;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] pc_target;

    assign instr_word = instr;
    assign opcode     = instr_word.r.opcode;

    control control_inst (
        .op                (opcode),
        .func3             (instr_word.r.funct3),
        .func7_5           (instr_word.r.funct7[5]),
        .alu_zero          (alu_zero),
        .alu_control       (alu_control),
        .imm_source        (imm_source),
        .mem_write         (mem_write),
        .reg_write         (reg_write),
        .alu_source        (alu_source),
        .write_back_source (write_back_source),
        .pc_source         (pc_source)
    );

    imm_extend imm_extend_inst (
        .instr      (instr_word),
        .imm_source (imm_source),
        .imm        (imm)
    );

    // No architectural writes while in reset
    assign rf_write_en = reg_write & ~rst;

    reg_file reg_file_inst (
        .clk        (clk),
        .rst        (rst),
        .read_addr1 (instr_word.r.rs1),
        .read_addr2 (instr_word.r.rs2),
        .write_addr (instr_word.r.rd),
        .write_en   (rf_write_en),
        .write_data (write_back),
        .read_data1 (rs1_data),
        .read_data2 (rs2_data)
    );

    assign alu_b = alu_source ? imm : rs2_data;

    alu alu_inst (
        .a           (rs1_data),
        .b           (alu_b),
        .alu_control (alu_control),
        .result      (alu_result),
        .zero        (alu_zero)
    );

    // Data memory side
    assign data_addr  = alu_result;
    assign data_wdata = rs2_data;
    assign data_we    = mem_write & ~rst;

    assign pc_plus4  = pc + `RV_XLEN'd4;
    assign pc_target = pc + imm;

    always_comb begin
        case (write_back_source)
            WB_MEM:  write_back = data_rdata;
            WB_PC4:  write_back = pc_plus4;
            default: write_back = alu_result;
        endcase
    end

    // One instruction per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pc_source ? pc_target : pc_plus4;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/imm_extend.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_extend (
    input  rv_pkg::instr_t   instr,
    input  rv_pkg::imm_src_t imm_source,
    output logic [31:0]      imm
);

    import rv_pkg::*;

    always_comb begin
        case (imm_source)
            IMM_I: begin
                imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            IMM_S: begin
                imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            end
            IMM_B: begin
                // Halfword offset, bit 0 always clear
                imm = {{19{instr.b.imm_12}},
                       instr.b.imm_12,
                       instr.b.imm_11,
                       instr.b.imm_10_5,
                       instr.b.imm_4_1,
                       1'b0};
            end
            IMM_J: begin
                imm = {{11{instr.j.imm_20}},
                       instr.j.imm_20,
                       instr.j.imm_19_12,
                       instr.j.imm_11,
                       instr.j.imm_10_1,
                       1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          read_addr1,
    input  logic [4:0]          read_addr2,
    input  logic [4:0]          write_addr,
    input  logic                write_en,
    input  logic [`RV_XLEN-1:0] write_data,
    output logic [`RV_XLEN-1:0] read_data1,
    output logic [`RV_XLEN-1:0] read_data2
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    // Write on the edge; x0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `RV_NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (write_en && (write_addr != 5'd0)) begin
            regs[write_addr] <= write_data;
        end
    end

    // Asynchronous reads, a same-cycle write is not forwarded
    always_comb begin
        read_data1 = regs[read_addr1];
        read_data2 = regs[read_addr2];
        if (read_addr1 == 5'd0) begin
            read_data1 = '0;
        end
        if (read_addr2 == 5'd0) begin
            read_data2 = '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // ALU operation select
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SUB  = 3'b001,
        ALU_AND  = 3'b010,
        ALU_OR   = 3'b011,
        ALU_NONE = 3'b111
    } alu_ctrl_t;

    // Which instruction format the immediate comes from
    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10,
        IMM_J = 2'b11
    } imm_src_t;

    // Register write-back source
    typedef enum logic [1:0] {
        WB_ALU = 2'b00,
        WB_MEM = 2'b01,
        WB_PC4 = 2'b10
    } wb_src_t;

    // One instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_t;

endpackage

`default_nettype wire
